// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --timing --assert --timescale 1ns/1ps
TB_TOP     = scaler_tb
RTL_TOP    = scaler
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TB_TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
source/scaler_pkg.sv
source/video_if.sv
source/scale_regs.sv
source/scaler_h.sv
source/line_buffer.sv
source/scaler_v.sv
source/scaler.sv
test/scaler_tb.sv

// ==== source/line_buffer.sv ====
//##########################################################################
// Memory for one scaled line. Registered read, a read of the address
// being written returns the old pixel.
//##########################################################################
`timescale 1ns/1ps

module line_buffer #(
    parameter int PIXEL_WIDTH      = 12,
    parameter int LINE_IN_SIZE_MAX = 1024
) (
    input  logic                                clk,
    input  logic                                wr_en_i,
    input  logic [$clog2(LINE_IN_SIZE_MAX)-1:0] wr_addr_i,
    input  logic [PIXEL_WIDTH-1:0]              wr_data_i,
    input  logic [$clog2(LINE_IN_SIZE_MAX)-1:0] rd_addr_i,
    output logic [PIXEL_WIDTH-1:0]              rd_data_o
);

    logic [PIXEL_WIDTH-1:0] mem [LINE_IN_SIZE_MAX];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];  // Read before write
    end

endmodule

// ==== source/scale_regs.sv ====
//##########################################################################
// Input register stage. Delays the raw stream by one cycle and latches
// the clamped scale steps once per frame on the rising edge of vs.
//##########################################################################
`timescale 1ns/1ps

module scale_regs #(
    parameter int PIXEL_WIDTH = 12
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [scaler_pkg::STEP_W-1:0] h_scale_step_i,
    input  logic [scaler_pkg::STEP_W-1:0] v_scale_step_i,
    input  logic [PIXEL_WIDTH-1:0]        pix_i,
    input  logic                          de_i,
    input  logic                          hs_i,
    input  logic                          vs_i,
    video_if.source                       vid,
    output logic [scaler_pkg::STEP_W-1:0] h_step_o,
    output logic [scaler_pkg::STEP_W-1:0] v_step_o
);

    logic [PIXEL_WIDTH-1:0] pix_q;
    logic                   de_q;
    logic                   hs_q;
    logic                   vs_q;
    logic                   frame_start;

    // No upscaling, anything below 1.0 becomes 1.0
    function automatic logic [scaler_pkg::STEP_W-1:0] clamp_step(
        input logic [scaler_pkg::STEP_W-1:0] step
    );
        return (step < scaler_pkg::UNITY_STEP) ? scaler_pkg::UNITY_STEP : step;
    endfunction

    assign frame_start = vs_i && !vs_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            de_q     <= 1'b0;
            hs_q     <= 1'b0;
            vs_q     <= 1'b0;
            h_step_o <= scaler_pkg::UNITY_STEP;
            v_step_o <= scaler_pkg::UNITY_STEP;
        end else begin
            de_q <= de_i;
            hs_q <= hs_i;
            vs_q <= vs_i;
            if (frame_start) begin  // Ratios fixed for the whole frame
                h_step_o <= clamp_step(h_scale_step_i);
                v_step_o <= clamp_step(v_scale_step_i);
            end
        end
    end

    always_ff @(posedge clk) begin
        pix_q <= pix_i;
    end

    assign vid.pix = pix_q;
    assign vid.de  = de_q;
    assign vid.hs  = hs_q;
    assign vid.vs  = vs_q;

endmodule

// ==== source/scaler.sv ====
//##########################################################################
// Top of the two-stage video downscaler. Plain stream ports, five cycles
// from an input pixel to the output pixel it produces.
//##########################################################################
`timescale 1ns/1ps

module scaler #(
    parameter int PIXEL_WIDTH      = 12,
    parameter int COE_WIDTH        = 10,
    parameter int LINE_IN_SIZE_MAX = 1024
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [scaler_pkg::STEP_W-1:0] h_scale_step_i,  // 4.12, sampled per frame
    input  logic [scaler_pkg::STEP_W-1:0] v_scale_step_i,
    input  logic [PIXEL_WIDTH-1:0]        pix_i,
    input  logic                          de_i,
    input  logic                          hs_i,
    input  logic                          vs_i,
    output logic [PIXEL_WIDTH-1:0]        pix_o,
    output logic                          de_o,
    output logic                          hs_o,
    output logic                          vs_o
);

    logic [scaler_pkg::STEP_W-1:0] h_step;
    logic [scaler_pkg::STEP_W-1:0] v_step;

    video_if #(.PIXEL_WIDTH(PIXEL_WIDTH)) in_vid ();
    video_if #(.PIXEL_WIDTH(PIXEL_WIDTH)) h_vid ();

    scale_regs #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) i_scale_regs (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .h_scale_step_i (h_scale_step_i),
        .v_scale_step_i (v_scale_step_i),
        .pix_i          (pix_i),
        .de_i           (de_i),
        .hs_i           (hs_i),
        .vs_i           (vs_i),
        .vid            (in_vid.source),
        .h_step_o       (h_step),
        .v_step_o       (v_step)
    );

    scaler_h #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .COE_WIDTH        (COE_WIDTH),
        .LINE_IN_SIZE_MAX (LINE_IN_SIZE_MAX)
    ) i_scaler_h (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .step_i  (h_step),
        .vid_in  (in_vid.sink),
        .vid_out (h_vid.source)
    );

    scaler_v #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .COE_WIDTH        (COE_WIDTH),
        .LINE_IN_SIZE_MAX (LINE_IN_SIZE_MAX)
    ) i_scaler_v (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .step_i  (v_step),
        .vid_in  (h_vid.sink),
        .pix_o   (pix_o),
        .de_o    (de_o),
        .hs_o    (hs_o),
        .vs_o    (vs_o)
    );

endmodule

// ==== source/scaler_h.sv ====
//##########################################################################
// Horizontal downscaler. A per-line phase accumulator picks the output
// positions and a two-stage pipeline blends neighbouring pixels.
//##########################################################################
`timescale 1ns/1ps

module scaler_h #(
    parameter int PIXEL_WIDTH      = 12,
    parameter int COE_WIDTH        = 10,
    parameter int LINE_IN_SIZE_MAX = 1024
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [scaler_pkg::STEP_W-1:0] step_i,
    video_if.sink                         vid_in,
    video_if.source                       vid_out
);

    localparam int CNT_W  = $clog2(LINE_IN_SIZE_MAX) + 1;
    localparam int POS_W  = CNT_W + scaler_pkg::FRAC_W;
    localparam int PROD_W = PIXEL_WIDTH + COE_WIDTH + 1;
    localparam int SUM_W  = PROD_W + 1;

    scaler_pkg::span_state_e state_q;
    logic [CNT_W-1:0]        cnt_q;   // Index of the previous pixel
    logic [POS_W-1:0]        pos_q;   // Position of the next output
    logic [PIXEL_WIDTH-1:0]  prev_q;
    logic                    emit;
    logic [COE_WIDTH-1:0]    w;
    logic [COE_WIDTH:0]      w_inv;
    logic [PROD_W-1:0]       prod_a_q;
    logic [PROD_W-1:0]       prod_b_q;
    logic [SUM_W-1:0]        sum;
    logic                    emit_q;
    logic                    hs_q;
    logic                    vs_q;
    logic [PIXEL_WIDTH-1:0]  pix_q2;
    logic                    de_q2;
    logic                    hs_q2;
    logic                    vs_q2;

    // Output when the integer part of the position lands on the previous pixel
    assign emit  = vid_in.de && (state_q != scaler_pkg::SPAN_IDLE) &&
                   (pos_q[POS_W-1:scaler_pkg::FRAC_W] == cnt_q);
    assign w     = pos_q[scaler_pkg::FRAC_W-1 -: COE_WIDTH];
    assign w_inv = {1'b1, {COE_WIDTH{1'b0}}} - {1'b0, w};
    assign sum   = SUM_W'(prod_a_q) + SUM_W'(prod_b_q);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= scaler_pkg::SPAN_IDLE;
            cnt_q   <= '0;
            pos_q   <= '0;
        end else if (vid_in.hs || vid_in.vs) begin  // New line
            state_q <= scaler_pkg::SPAN_IDLE;
            cnt_q   <= '0;
            pos_q   <= '0;
        end else if (vid_in.de) begin
            if (state_q == scaler_pkg::SPAN_IDLE) begin
                state_q <= scaler_pkg::SPAN_FIRST;  // Held as predecessor only
            end else begin
                state_q <= scaler_pkg::SPAN_ACTIVE;
                cnt_q   <= cnt_q + 1'b1;
                if (emit) begin
                    pos_q <= pos_q + POS_W'(step_i);
                end
            end
        end
    end

    // Sync and valid pipeline, 2 cycles
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            emit_q <= 1'b0;
            hs_q   <= 1'b0;
            vs_q   <= 1'b0;
            de_q2  <= 1'b0;
            hs_q2  <= 1'b0;
            vs_q2  <= 1'b0;
        end else begin
            emit_q <= emit;
            hs_q   <= vid_in.hs;
            vs_q   <= vid_in.vs;
            de_q2  <= emit_q;
            hs_q2  <= hs_q;
            vs_q2  <= vs_q;
        end
    end

    always_ff @(posedge clk) begin
        if (vid_in.de) begin
            prev_q <= vid_in.pix;
        end
        prod_a_q <= PROD_W'(prev_q) * PROD_W'(w_inv);      // a * (1 - w)
        prod_b_q <= PROD_W'(vid_in.pix) * PROD_W'(w);      // b * w
        pix_q2   <= sum[COE_WIDTH +: PIXEL_WIDTH];
    end

    assign vid_out.pix = pix_q2;
    assign vid_out.de  = de_q2;
    assign vid_out.hs  = hs_q2;
    assign vid_out.vs  = vs_q2;

endmodule

// ==== source/scaler_pkg.sv ====
//##########################################################################
// Shared constants and types of the downscaler. Modules refer to them by
// scoped names.
//##########################################################################
package scaler_pkg;

    // Scale step in 4.12 fixed point
    localparam int STEP_W = 16;
    localparam int FRAC_W = 12;

    // Ratio 1.0, also the floor for any programmed step
    localparam logic [STEP_W-1:0] UNITY_STEP = STEP_W'(1 << FRAC_W);

    // Progress through a line (horizontal) or a frame (vertical)
    typedef enum logic [1:0] {
        SPAN_IDLE,   // Span not started yet
        SPAN_FIRST,  // First sample seen, no predecessor
        SPAN_ACTIVE  // Interpolation possible
    } span_state_e;

endpackage

// ==== source/scaler_v.sv ====
//##########################################################################
// Vertical downscaler. Blends each column of the current line with the
// same column of the buffered previous line and registers the outputs.
//##########################################################################
`timescale 1ns/1ps

module scaler_v #(
    parameter int PIXEL_WIDTH      = 12,
    parameter int COE_WIDTH        = 10,
    parameter int LINE_IN_SIZE_MAX = 1024
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [scaler_pkg::STEP_W-1:0] step_i,
    video_if.sink                         vid_in,
    output logic [PIXEL_WIDTH-1:0]        pix_o,
    output logic                          de_o,
    output logic                          hs_o,
    output logic                          vs_o
);

    localparam int AW     = $clog2(LINE_IN_SIZE_MAX);
    localparam int LN_W   = 16;
    localparam int LPOS_W = LN_W + scaler_pkg::FRAC_W;
    localparam int PROD_W = PIXEL_WIDTH + COE_WIDTH + 1;
    localparam int SUM_W  = PROD_W + 1;

    scaler_pkg::span_state_e state_q;
    logic [AW-1:0]           col_q;
    logic                    in_line_q;
    logic [LN_W-1:0]         line_q;        // Index of the previous line
    logic [LPOS_W-1:0]       lpos_q;        // Line position of the next output
    logic                    emit_line_q;
    logic [COE_WIDTH-1:0]    w_line_q;
    logic                    line_start;
    logic                    start_emit;
    logic                    emit_now;
    logic [COE_WIDTH-1:0]    w_now;
    logic [PIXEL_WIDTH-1:0]  old_pix;
    logic [PIXEL_WIDTH-1:0]  b_q;
    logic [COE_WIDTH-1:0]    w_q;
    logic [COE_WIDTH:0]      w_inv;
    logic [SUM_W-1:0]        sum;
    logic                    de_q;
    logic                    hs_q;
    logic                    vs_q;

    // Old line j-1 read at the column being overwritten by line j
    line_buffer #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .LINE_IN_SIZE_MAX (LINE_IN_SIZE_MAX)
    ) i_line_buffer (
        .clk       (clk),
        .wr_en_i   (vid_in.de),
        .wr_addr_i (col_q),
        .wr_data_i (vid_in.pix),
        .rd_addr_i (col_q),
        .rd_data_o (old_pix)
    );

    // Line decision is taken on its first pixel and held for the line
    assign line_start = vid_in.de && !in_line_q;
    assign start_emit = (state_q != scaler_pkg::SPAN_IDLE) &&
                        (lpos_q[LPOS_W-1:scaler_pkg::FRAC_W] == line_q);
    assign emit_now   = line_start ? start_emit : emit_line_q;
    assign w_now      = line_start ? lpos_q[scaler_pkg::FRAC_W-1 -: COE_WIDTH] : w_line_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= scaler_pkg::SPAN_IDLE;
            col_q       <= '0;
            in_line_q   <= 1'b0;
            line_q      <= '0;
            lpos_q      <= '0;
            emit_line_q <= 1'b0;
            w_line_q    <= '0;
        end else if (vid_in.vs) begin  // Frame restart
            state_q     <= scaler_pkg::SPAN_IDLE;
            col_q       <= '0;
            in_line_q   <= 1'b0;
            line_q      <= '0;
            lpos_q      <= '0;
            emit_line_q <= 1'b0;
        end else if (vid_in.hs) begin
            col_q     <= '0;
            in_line_q <= 1'b0;
        end else if (vid_in.de) begin
            col_q     <= col_q + 1'b1;
            in_line_q <= 1'b1;
            if (line_start) begin
                emit_line_q <= start_emit;
                w_line_q    <= w_now;
                if (state_q == scaler_pkg::SPAN_IDLE) begin
                    state_q <= scaler_pkg::SPAN_FIRST;  // Only fills the buffer
                end else begin
                    state_q <= scaler_pkg::SPAN_ACTIVE;
                    line_q  <= line_q + 1'b1;
                    if (start_emit) begin
                        lpos_q <= lpos_q + LPOS_W'(step_i);
                    end
                end
            end
        end
    end

    assign w_inv = {1'b1, {COE_WIDTH{1'b0}}} - {1'b0, w_q};
    assign sum   = SUM_W'(PROD_W'(old_pix) * PROD_W'(w_inv)) +
                   SUM_W'(PROD_W'(b_q) * PROD_W'(w_q));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            de_q <= 1'b0;
            hs_q <= 1'b0;
            vs_q <= 1'b0;
            de_o <= 1'b0;
            hs_o <= 1'b0;
            vs_o <= 1'b0;
        end else begin
            de_q <= vid_in.de && emit_now;
            hs_q <= vid_in.hs;
            vs_q <= vid_in.vs;
            de_o <= de_q;
            hs_o <= hs_q;
            vs_o <= vs_q;
        end
    end

    always_ff @(posedge clk) begin
        b_q   <= vid_in.pix;  // Aligned with the buffer read
        w_q   <= w_now;
        pix_o <= sum[COE_WIDTH +: PIXEL_WIDTH];
    end

endmodule

// ==== source/video_if.sv ====
//##########################################################################
// Pixel stream between the scaler stages, one pixel per cycle with
// de/hs/vs levels. Source drives, sink reads.
//##########################################################################
`timescale 1ns/1ps

interface video_if #(
    parameter int PIXEL_WIDTH = 12
) ();

    logic [PIXEL_WIDTH-1:0] pix;  // Valid while de is high
    logic                   de;
    logic                   hs;   // Line sync
    logic                   vs;   // Frame sync, never with de

    modport source (
        output pix, de, hs, vs
    );

    modport sink (
        input pix, de, hs, vs
    );

endinterface

// ==== test/scaler_tb.sv ====
//##########################################################################
// Random-stimulus testbench for the downscaler. A model of the stepping
// rules predicts each output pixel. Run it through the Makefile.
//##########################################################################
`timescale 1ns/1ps

module scaler_tb;

    localparam int PIXEL_WIDTH = 12;
    localparam int COE_WIDTH   = 10;
    localparam int LINE_MAX    = 1024;
    localparam int FRAC_BITS   = 12;
    localparam int UNITY       = 4096;  // Ratio 1.0
    localparam int MAX_LINES   = 20;
    localparam int MAX_PIX     = 64;
    localparam int DRAIN_LIMIT = 200;

    logic                   clk;
    logic                   rst_n;
    logic [15:0]            h_step;
    logic [15:0]            v_step;
    logic [PIXEL_WIDTH-1:0] pix;
    logic                   de;
    logic                   hs;
    logic                   vs;
    logic [PIXEL_WIDTH-1:0] pix_o;
    logic                   de_o;
    logic                   hs_o;
    logic                   vs_o;

    logic [31:0]            rng_state;
    logic [PIXEL_WIDTH-1:0] frame_pix [MAX_LINES][MAX_PIX];
    int                     hline [MAX_LINES][MAX_PIX];  // Horizontally scaled lines
    logic [PIXEL_WIDTH-1:0] exp_q [$];
    logic [4:0]             hs_hist;  // Input syncs at the last five rising edges
    logic [4:0]             vs_hist;
    bit                     timed_out;
    int                     n_lines;
    int                     n_pix;
    int                     frame_exp;  // Expected outputs of the current frame
    int                     rx_count;
    int                     errors;
    int                     checks;
    int                     tests_run;
    int                     tests_failed;

    scaler #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .COE_WIDTH        (COE_WIDTH),
        .LINE_IN_SIZE_MAX (LINE_MAX)
    ) i_scaler (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .h_scale_step_i (h_step),
        .v_scale_step_i (v_step),
        .pix_i          (pix),
        .de_i           (de),
        .hs_i           (hs),
        .vs_i           (vs),
        .pix_o          (pix_o),
        .de_o           (de_o),
        .hs_o           (hs_o),
        .vs_o           (vs_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Sync delay line, five cycles like the DUT
    always @(posedge clk) begin
        hs_hist <= {hs_hist[3:0], hs};
        vs_hist <= {vs_hist[3:0], vs};
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] span;
        rng_state = xorshift32(rng_state);
        span      = 32'(hi - lo + 1);
        return lo + int'(rng_state % span);
    endfunction

    // Weight is the top COE_WIDTH bits of the position fraction
    function automatic int blend(input int a, input int b, input int pos);
        int w;
        w = (pos >> (FRAC_BITS - COE_WIDTH)) % (1 << COE_WIDTH);
        return (a * ((1 << COE_WIDTH) - w) + b * w) >> COE_WIDTH;
    endfunction

    function automatic int effective_step(input logic [15:0] s);
        return (int'(s) < UNITY) ? UNITY : int'(s);  // No upscaling
    endfunction

    // Horizontal pass per line and a vertical pass over the scaled lines
    task automatic predict_frame(input logic [15:0] hst, input logic [15:0] vst);
        int hpos;
        int lpos;
        int width;
        frame_exp = 0;
        width     = 0;
        for (int l = 0; l < n_lines; l++) begin
            hpos  = 0;
            width = 0;
            for (int i = 1; i < n_pix; i++) begin
                if ((hpos >> FRAC_BITS) == i - 1) begin
                    hline[l][width] = blend(int'(frame_pix[l][i-1]),
                                            int'(frame_pix[l][i]), hpos);
                    width++;
                    hpos += effective_step(hst);
                end
            end
        end
        lpos = 0;
        for (int j = 1; j < n_lines; j++) begin
            if ((lpos >> FRAC_BITS) == j - 1) begin
                for (int c = 0; c < width; c++) begin
                    exp_q.push_back(PIXEL_WIDTH'(blend(hline[j-1][c], hline[j][c], lpos)));
                    frame_exp++;
                end
                lpos += effective_step(vst);
            end
        end
    endtask

    task automatic send_frame(input logic [15:0] hst, input logic [15:0] vst,
                              input int max_gap, input bit rewrite,
                              input logic [15:0] new_h, input logic [15:0] new_v);
        int gap;
        n_lines = rand_range(6, MAX_LINES);
        n_pix   = rand_range(8, MAX_PIX);
        for (int l = 0; l < n_lines; l++) begin
            for (int i = 0; i < n_pix; i++) begin
                frame_pix[l][i] = PIXEL_WIDTH'(rand_range(0, 4095));
            end
        end
        predict_frame(hst, vst);
        @(negedge clk);
        h_step = hst;
        v_step = vst;
        vs     = 1'b1;
        repeat (2) @(negedge clk);
        vs = 1'b0;
        for (int l = 0; l < n_lines; l++) begin
            if (rewrite && l == n_lines / 2) begin  // Must wait for the next frame
                h_step = new_h;
                v_step = new_v;
            end
            @(negedge clk);
            hs = 1'b1;
            @(negedge clk);
            hs = 1'b0;
            for (int i = 0; i < n_pix; i++) begin
                gap = rand_range(0, max_gap);
                if (gap > 0) begin
                    de = 1'b0;
                    repeat (gap) @(negedge clk);
                end
                de  = 1'b1;
                pix = frame_pix[l][i];
                @(negedge clk);
            end
            de = 1'b0;
        end
    endtask

    task automatic drain_frame(input int rx_start);
        int cycles;
        cycles = 0;
        while (rx_count - rx_start < frame_exp && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (rx_count - rx_start < frame_exp) begin
            $display("Timeout: frame output stopped %0d pixels short after %0d cycles",
                     frame_exp - (rx_count - rx_start), DRAIN_LIMIT);
            errors++;
            timed_out = 1'b1;
        end else begin
            repeat (8) @(posedge clk);  // Surplus pixels would appear here
            checks++;
            assert (rx_count - rx_start == frame_exp) else begin
                $display("FAILED time %0t de_o count got %0d expected %0d",
                         $time, rx_count - rx_start, frame_exp);
                errors++;
            end
        end
    endtask

    task automatic run_frame(input logic [15:0] hst, input logic [15:0] vst,
                             input int max_gap, input bit rewrite,
                             input logic [15:0] new_h, input logic [15:0] new_v);
        int rx_start;
        if (!timed_out) begin
            rx_start = rx_count;
            send_frame(hst, vst, max_gap, rewrite, new_h, new_v);
            drain_frame(rx_start);
        end
    endtask

    task automatic close_test(input string name, input int err_start);
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_start);
        end else if (timed_out) begin
            $display("test %0d %s: not run after a timeout", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    // Output monitor with in-order pixel compare
    always @(negedge clk) begin : monitor
        logic [PIXEL_WIDTH-1:0] expected;
        if (rst_n) begin
            checks++;
            assert (hs_o == hs_hist[4] && vs_o == vs_hist[4]) else begin
                $display("FAILED time %0t hs_o/vs_o got %b%b expected %b%b",
                         $time, hs_o, vs_o, hs_hist[4], vs_hist[4]);
                errors++;
            end
        end
        if (rst_n && de_o) begin
            rx_count++;
            checks++;
            assert (exp_q.size() > 0) else begin
                $display("Unexpected output pixel at %0t ns, the model has none left", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                assert (pix_o == expected) else begin
                    $display("FAILED time %0t pix_o got %0d expected %0d",
                             $time, pix_o, expected);
                    errors++;
                end
            end
        end
    end

    initial begin
        int          err_start;
        logic [15:0] step_a;
        logic [15:0] step_b;
        rng_state    = 32'had10a620;
        rx_count     = 0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        hs_hist      = '0;
        vs_hist      = '0;
        rst_n        = 1'b0;
        h_step       = 16'(UNITY);
        v_step       = 16'(UNITY);
        pix          = '0;
        de           = 1'b0;
        hs           = 1'b0;
        vs           = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        err_start = errors;
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            checks++;
            assert (!de_o && !hs_o && !vs_o) else begin
                $display("FAILED time %0t de_o/hs_o/vs_o got %b%b%b expected 000",
                         $time, de_o, hs_o, vs_o);
                errors++;
            end
        end
        close_test("idle after reset", err_start);

        err_start = errors;
        run_frame(16'(UNITY), 16'(UNITY), 0, 1'b0, 16'h0, 16'h0);  // Dense
        run_frame(16'(UNITY), 16'(UNITY), 3, 1'b0, 16'h0, 16'h0);
        close_test("unity steps", err_start);

        err_start = errors;
        run_frame(16'h2000, 16'(UNITY), 1, 1'b0, 16'h0, 16'h0);
        close_test("horizontal step 2.0", err_start);

        err_start = errors;
        for (int f = 0; f < 5; f++) begin
            step_a = 16'(rand_range(UNITY, 4 * UNITY));
            step_b = 16'(rand_range(UNITY, 4 * UNITY));
            run_frame(step_a, step_b, rand_range(0, 3), 1'b0, 16'h0, 16'h0);
        end
        close_test("random steps", err_start);

        err_start = errors;
        step_a = 16'(rand_range(UNITY, 4 * UNITY));
        step_b = 16'(rand_range(UNITY, 4 * UNITY));
        run_frame(step_a, step_b, 2, 1'b1, step_b, step_a);
        run_frame(step_b, step_a, 2, 1'b0, 16'h0, 16'h0);
        close_test("step change mid-frame", err_start);

        err_start = errors;
        step_a = 16'(rand_range(0, UNITY - 1));
        step_b = 16'(rand_range(0, UNITY - 1));
        run_frame(step_a, step_b, 1, 1'b0, 16'h0, 16'h0);
        close_test("steps below unity", err_start);

        $display("Tests %0d run, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
